// ==== rtl/sportPkg.sv ====
package sportPkg;

  // Word length field holds length minus one
  localparam int lenWidth = 4;

  // Words-per-frame field and internal frame period
  localparam int wordCntWidth = 8;

  // Slot number shown to the host
  localparam int slotWidth = 4;

  localparam int defaultDataWidth = 16;

  // Transmit controller state, one-hot
  typedef enum logic [2:0] {
    txIdle   = 3'b001,  // Waiting for frame sync
    txShift  = 3'b010,  // Serializing a word
    txWstart = 3'b100   // One-cycle gap between words of a frame
  } txStateT;

endpackage

// ==== rtl/txWordIf.sv ====
`timescale 1ns/1ps

interface txWordIf #(
  parameter int dataWidth = sportPkg::defaultDataWidth
) ();

  logic [dataWidth-1:0] txWord;      // Holding register content
  logic                 loadWord;    // Shift register takes txWord at this edge
  logic                 frameStart;  // First shift cycle after idle
  sportPkg::txStateT    state;       // Controller state

  modport bufSide (
    output txWord,
    input  loadWord,
    input  frameStart
  );

  modport ctlSide (
    input  txWord,
    output loadWord,
    output frameStart,
    output state
  );

  modport outSide (
    input frameStart,
    input state
  );

endinterface

// ==== rtl/frameSyncGen.sv ====
`timescale 1ns/1ps

module frameSyncGen (
  input  logic                              SCLKg5,
  input  logic                              rst_SP_ENg,
  input  logic                              spEn,
  input  logic                              internalFs,
  input  logic [sportPkg::wordCntWidth-1:0] framePeriod,
  input  logic                              tfsIn,
  output logic                              tfs
);

  logic [sportPkg::wordCntWidth-1:0] periodCnt;
  logic                              tfsInQ;
  logic                              intPulse;
  logic                              extPulse;

  // Internal sync fires when the divider wraps
  assign intPulse = spEn && (periodCnt == '0);

  // Rising edge of the external level sync
  assign extPulse = tfsIn && !tfsInQ;

  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      periodCnt <= '0;
    end else if (!spEn) begin
      periodCnt <= '0;  // Restart so the first pulse is immediate
    end else if (periodCnt == '0) begin
      periodCnt <= framePeriod;
    end else begin
      periodCnt <= periodCnt - 1'b1;
    end
  end

  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      tfsInQ <= 1'b0;
    end else begin
      tfsInQ <= tfsIn;
    end
  end

  // One registered pulse per frame from the selected source
  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      tfs <= 1'b0;
    end else if (internalFs) begin
      tfs <= intPulse;
    end else begin
      tfs <= extPulse;
    end
  end

endmodule

// ==== rtl/txWordBuffer.sv ====
`timescale 1ns/1ps

module txWordBuffer #(
  parameter int dataWidth = sportPkg::defaultDataWidth
) (
  input  logic                 SCLKg5,
  input  logic                 rst_SP_ENg,
  input  logic                 txWrite,
  input  logic                 dmaAck,
  input  logic [dataWidth-1:0] txData,
  input  logic                 autoBuf,
  output logic                 dmaReq,
  txWordIf.bufSide             wordBus
);

  logic [dataWidth-1:0] holdReg;
  logic                 holdWe;
  logic                 reqSet;
  logic                 reqClr;

  // Core write or DMA acknowledge both carry data on txData
  assign holdWe = txWrite || dmaAck;

  // Holding register, the old word is resent if nobody refills it
  always_ff @(posedge SCLKg5) begin
    if (holdWe) begin
      holdReg <= txData;
    end
  end

  assign wordBus.txWord = holdReg;

  // In autobuffer mode each taken word asks for the next one
  assign reqSet = autoBuf && wordBus.loadWord;
  assign reqClr = dmaAck;

  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      dmaReq <= 1'b0;
    end else if (reqClr) begin
      dmaReq <= 1'b0;  // Acknowledge wins
    end else if (reqSet) begin
      dmaReq <= 1'b1;
    end
  end

endmodule

// ==== rtl/txShiftCtl.sv ====
`timescale 1ns/1ps

module txShiftCtl #(
  parameter int dataWidth = sportPkg::defaultDataWidth
) (
  input  logic                              SCLKg5,
  input  logic                              rst_SP_ENg,
  input  logic                              tfs,
  input  logic [sportPkg::lenWidth-1:0]     wordLen,
  input  logic [sportPkg::wordCntWidth-1:0] wordsPerFrame,
  output logic [sportPkg::slotWidth-1:0]    slotNum,
  output logic                              msbBit,
  txWordIf.ctlSide                          wordBus
);

  sportPkg::txStateT                 state;
  sportPkg::txStateT                 nextState;
  logic [sportPkg::lenWidth-1:0]     bitCnt;
  logic [sportPkg::wordCntWidth-1:0] wordCnt;
  logic [dataWidth-1:0]              shiftReg;
  logic                              frameLoad;
  logic                              lastBit;
  logic                              lastWord;

  assign lastBit   = (bitCnt == '0);
  assign lastWord  = (wordCnt == '0);
  assign frameLoad = (state == sportPkg::txIdle) && tfs;  // Syncs outside idle drop here

  always_comb begin
    case (state)
      sportPkg::txIdle:   nextState = tfs ? sportPkg::txShift : sportPkg::txIdle;
      sportPkg::txShift: begin
        if (lastBit) begin
          nextState = lastWord ? sportPkg::txIdle : sportPkg::txWstart;
        end else begin
          nextState = sportPkg::txShift;
        end
      end
      sportPkg::txWstart: nextState = sportPkg::txShift;
      default:            nextState = sportPkg::txIdle;
    endcase
  end

  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      state <= sportPkg::txIdle;
    end else begin
      state <= nextState;
    end
  end

  // Entering shift from idle or wait-start takes a new word
  assign wordBus.loadWord = (state != sportPkg::txShift) && (nextState == sportPkg::txShift);
  assign wordBus.state    = state;

  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      wordBus.frameStart <= 1'b0;
    end else begin
      wordBus.frameStart <= frameLoad;
    end
  end

  // Bit counter, wordLen+1 shift cycles per word
  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      bitCnt <= '0;
    end else if (wordBus.loadWord) begin
      bitCnt <= wordLen;
    end else if (state == sportPkg::txShift && !lastBit) begin
      bitCnt <= bitCnt - 1'b1;
    end
  end

  // Word counter, counts the extra words of a frame
  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      wordCnt <= '0;
    end else if (frameLoad) begin
      wordCnt <= wordsPerFrame;
    end else if (nextState == sportPkg::txWstart) begin
      wordCnt <= wordCnt - 1'b1;
    end
  end

  assign slotNum = wordCnt[sportPkg::slotWidth-1:0];

  always_ff @(posedge SCLKg5) begin
    if (wordBus.loadWord) begin
      shiftReg <= wordBus.txWord;
    end else if (state == sportPkg::txShift) begin
      shiftReg <= {shiftReg[dataWidth-2:0], 1'b0};
    end
  end

  // MSB sits at bit wordLen, not at the top of the register
  assign msbBit = shiftReg[wordLen];

endmodule

// ==== rtl/txSerialOut.sv ====
`timescale 1ns/1ps

module txSerialOut (
  input  logic     SCLKg5,
  input  logic     rst_SP_ENg,
  input  logic     msbBit,
  input  logic     autoBuf,
  input  logic     dmaWrap,
  output logic     td,
  output logic     tdEn,
  output logic     ist,
  txWordIf.outSide wordBus
);

  logic shiftActive;
  logic autoBufQ;

  assign shiftActive = (wordBus.state == sportPkg::txShift);

  // Data pin is driven only while a word is on the wire
  assign tdEn = shiftActive;
  assign td   = shiftActive && msbBit;

  // Mode for the interrupt source changes only between frames
  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      autoBufQ <= 1'b0;
    end else if (wordBus.state == sportPkg::txIdle) begin
      autoBufQ <= autoBuf;
    end
  end

  // Autobuffer interrupts on DMA wrap, otherwise on frame start
  assign ist = autoBufQ ? dmaWrap : wordBus.frameStart;

endmodule

// ==== rtl/sportTx.sv ====
`timescale 1ns/1ps

module sportTx #(
  parameter int dataWidth = sportPkg::defaultDataWidth
) (
  input  logic                              SCLKg5,
  input  logic                              rst_SP_ENg,
  input  logic                              spEn,
  input  logic                              internalFs,
  input  logic [sportPkg::wordCntWidth-1:0] framePeriod,
  input  logic                              tfsIn,
  input  logic [sportPkg::lenWidth-1:0]     wordLen,
  input  logic [sportPkg::wordCntWidth-1:0] wordsPerFrame,
  input  logic                              autoBuf,
  input  logic                              txWrite,
  input  logic                              dmaAck,
  input  logic [dataWidth-1:0]              txData,
  input  logic                              dmaWrap,
  output logic                              td,
  output logic                              tdEn,
  output logic                              tfsOut,
  output logic                              dmaReq,
  output logic                              ist,
  output logic [sportPkg::slotWidth-1:0]    slotNum
);

  logic tfs;
  logic msbBit;

  txWordIf #(.dataWidth(dataWidth)) wordBus ();

  frameSyncGen fsGen (
    .SCLKg5      (SCLKg5),
    .rst_SP_ENg  (rst_SP_ENg),
    .spEn        (spEn),
    .internalFs  (internalFs),
    .framePeriod (framePeriod),
    .tfsIn       (tfsIn),
    .tfs         (tfs)
  );

  assign tfsOut = tfs;

  txWordBuffer #(.dataWidth(dataWidth)) wordBuf (
    .SCLKg5     (SCLKg5),
    .rst_SP_ENg (rst_SP_ENg),
    .txWrite    (txWrite),
    .dmaAck     (dmaAck),
    .txData     (txData),
    .autoBuf    (autoBuf),
    .dmaReq     (dmaReq),
    .wordBus    (wordBus.bufSide)
  );

  txShiftCtl #(.dataWidth(dataWidth)) shiftCtl (
    .SCLKg5        (SCLKg5),
    .rst_SP_ENg    (rst_SP_ENg),
    .tfs           (tfs),
    .wordLen       (wordLen),
    .wordsPerFrame (wordsPerFrame),
    .slotNum       (slotNum),
    .msbBit        (msbBit),
    .wordBus       (wordBus.ctlSide)
  );

  txSerialOut serialOut (
    .SCLKg5     (SCLKg5),
    .rst_SP_ENg (rst_SP_ENg),
    .msbBit     (msbBit),
    .autoBuf    (autoBuf),
    .dmaWrap    (dmaWrap),
    .td         (td),
    .tdEn       (tdEn),
    .ist        (ist),
    .wordBus    (wordBus.outSide)
  );

endmodule

// ==== tests/sportTxTb.sv ====
`timescale 1ns/1ps

module sportTxTb;

  localparam int dataWidth   = 16;
  localparam int periodSet   = 255;
  localparam int totalFrames = 26;  // 20 single, 2 multi, 2 auto, 1 ext, 1 ignored
  localparam longint watchdogNs = 2 * totalFrames * (periodSet + 1) * 20;

  logic                 SCLKg5;
  logic                 rst_SP_ENg;
  logic                 spEn;
  logic                 internalFs;
  logic [7:0]           framePeriod;
  logic                 tfsIn;
  logic [3:0]           wordLen;
  logic [7:0]           wordsPerFrame;
  logic                 autoBuf;
  logic                 txWrite;
  logic                 dmaAck;
  logic [dataWidth-1:0] txData;
  logic                 dmaWrap;
  logic                 td;
  logic                 tdEn;
  logic                 tfsOut;
  logic                 dmaReq;
  logic                 ist;
  logic [3:0]           slotNum;

  logic [31:0]          rng;
  logic [dataWidth-1:0] words [0:31];
  logic                 expQ[$];  // Expected td bits in send order
  int                   errCnt;
  int                   testsRun;
  int                   testsFailing;
  int                   errBefore;

  sportTx #(.dataWidth(dataWidth)) dut_i (
    .SCLKg5(SCLKg5), .rst_SP_ENg(rst_SP_ENg), .spEn(spEn), .internalFs(internalFs),
    .framePeriod(framePeriod), .tfsIn(tfsIn), .wordLen(wordLen),
    .wordsPerFrame(wordsPerFrame), .autoBuf(autoBuf), .txWrite(txWrite), .dmaAck(dmaAck),
    .txData(txData), .dmaWrap(dmaWrap), .td(td), .tdEn(tdEn), .tfsOut(tfsOut),
    .dmaReq(dmaReq), .ist(ist), .slotNum(slotNum)
  );

  initial begin
    SCLKg5 = 1'b0;
    forever #10 SCLKg5 = ~SCLKg5;
  end

  initial begin
    #(watchdogNs);
    $display("Timeout after %0d ns, the DUT stopped sending", watchdogNs);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Bit i of the result is the i-th bit on td, MSB at position len first
  function automatic logic [31:0] refSeq(input logic [dataWidth-1:0] word, input int len);
    logic [31:0] seq;
    seq = '0;
    for (int i = 0; i <= len; i++) begin
      seq[i] = word[len-i];
    end
    return seq;
  endfunction

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
      errCnt++;
    end
  endtask

  // Compare process, every enabled bit must match the head of the queue
  always @(negedge SCLKg5) begin
    if (!rst_SP_ENg && tdEn) begin
      if (expQ.size() == 0) begin
        $display("At %0t td was enabled but no bit was expected", $time);
        errCnt++;
      end else begin
        if (td !== expQ[0]) begin
          $display("FAILED t=%0t td expected %b got %b", $time, expQ[0], td);
          errCnt++;
        end
        void'(expQ.pop_front());
      end
    end
  end

  task automatic runFrame(input int len, input int n, input bit auto, input bit ext,
                          input bit inject);
    logic [31:0] seq;
    int          wordIdx;
    int          cycle;
    int          gap;
    int          ackIdx;
    int          ackStage;
    bit          prevEn;
    logic        prevTfs;
    bit          done;
    bit          doWrite;
    bit          doAck;
    logic        expIst;
    wordLen       = 4'(len);
    wordsPerFrame = 8'(n);
    autoBuf       = auto;
    internalFs    = !ext;
    framePeriod   = 8'(periodSet);
    txWrite       = 1'b1;
    txData        = words[0];
    for (int k = 0; k <= n; k++) begin
      seq = refSeq(words[k], len);
      for (int i = 0; i <= len; i++) begin
        expQ.push_back(seq[i]);
      end
    end
    @(posedge SCLKg5);
    #2;
    txWrite = 1'b0;
    @(posedge SCLKg5);  // Lets the interrupt mode settle in idle
    #2;
    if (ext) begin
      tfsIn = 1'b1;
    end else begin
      spEn = 1'b1;
    end
    wordIdx  = -1;
    cycle    = 0;
    gap      = 0;
    ackIdx   = 1;
    ackStage = 0;
    prevEn   = 1'b0;
    prevTfs  = 1'b0;
    done     = 1'b0;
    while (!done) begin
      @(negedge SCLKg5);
      doWrite = 1'b0;
      doAck   = 1'b0;
      if (tdEn && !prevEn) begin
        wordIdx++;
        if (ext && wordIdx == 0 && cycle != 2) begin
          $display("At %0t first td bit came %0d cycles after tfsIn rose, not 2", $time, cycle);
          errCnt++;
        end
        if (wordIdx > 0 && gap != 1) begin
          $display("At %0t gap between words was %0d cycles, not 1", $time, gap);
          errCnt++;
        end
        if (slotNum !== 4'(n - wordIdx)) begin
          $display("FAILED t=%0t slotNum expected %0d got %0d", $time, 4'(n - wordIdx), slotNum);
          errCnt++;
        end
        if (wordIdx == 0) begin
          checkBit("tfsOut", prevTfs, 1'b1);  // Sync pulse in the cycle before the MSB
        end
        checkBit("dmaReq", dmaReq, auto);  // Raised as each word is taken
        doWrite = !auto && (wordIdx < n);
      end
      expIst = auto ? dmaWrap : (tdEn && !prevEn && wordIdx == 0);
      if (ist !== expIst) begin
        $display("FAILED t=%0t ist expected %b got %b", $time, expIst, ist);
        errCnt++;
      end
      if (ackStage == 2) begin
        if (dmaReq !== 1'b0) begin
          $display("FAILED t=%0t dmaReq expected 0 got %b", $time, dmaReq);
          errCnt++;
        end
        ackStage = 0;
      end
      doAck = auto && dmaReq && (ackStage == 0);
      if (!tdEn) begin
        gap = prevEn ? 1 : gap + 1;
      end
      if (!tdEn && prevEn && wordIdx == n) begin
        done = 1'b1;
      end
      prevEn  = tdEn;
      prevTfs = tfsOut;
      @(posedge SCLKg5);
      #2;
      cycle++;
      txWrite = doWrite;
      dmaAck  = doAck;
      if (doWrite) begin
        txData = words[wordIdx+1];
      end
      if (doAck) begin
        rng      = xorshift(rng);
        txData   = (ackIdx <= n) ? words[ackIdx] : rng[dataWidth-1:0];
        ackIdx++;
        ackStage = 1;
      end else if (ackStage == 1) begin
        ackStage = 2;
      end
      if (auto) begin
        rng     = xorshift(rng);
        dmaWrap = rng[7];
      end
      if (ext) begin
        tfsIn = (cycle < 4) || (inject && cycle >= 6 && cycle < 9);  // Second edge lands mid-word
      end
    end
    spEn    = 1'b0;
    tfsIn   = 1'b0;
    dmaWrap = 1'b0;
    txWrite = 1'b0;
    dmaAck  = 1'b0;
    repeat (2) begin
      @(posedge SCLKg5);
      #2;
    end
    if (expQ.size() != 0) begin
      $display("At %0t frame ended with %0d expected bits not sent", $time, expQ.size());
      errCnt++;
      expQ.delete();
    end
  endtask

  task automatic closeTest(input string name);
    testsRun++;
    if (errCnt > errBefore) begin
      testsFailing++;
      $display("%s: FAILED with %0d errors", name, errCnt - errBefore);
    end else begin
      $display("%s: ok", name);
    end
    errBefore = errCnt;
  endtask

  task automatic fillWords();
    for (int k = 0; k < 32; k++) begin
      rng      = xorshift(rng);
      words[k] = rng[dataWidth-1:0];
    end
  endtask

  initial begin
    rst_SP_ENg    = 1'b1;
    spEn          = 1'b0;
    internalFs    = 1'b1;
    framePeriod   = '0;
    tfsIn         = 1'b0;
    wordLen       = '0;
    wordsPerFrame = '0;
    autoBuf       = 1'b0;
    txWrite       = 1'b0;
    dmaAck        = 1'b0;
    txData        = '0;
    dmaWrap       = 1'b0;
    rng           = 32'h4555;
    errCnt        = 0;
    errBefore     = 0;
    testsRun      = 0;
    testsFailing  = 0;
    repeat (4) @(posedge SCLKg5);
    #2;
    rst_SP_ENg = 1'b0;
    @(negedge SCLKg5);
    checkBit("tdEn", tdEn, 1'b0);
    checkBit("ist", ist, 1'b0);
    checkBit("dmaReq", dmaReq, 1'b0);
    checkBit("tfsOut", tfsOut, 1'b0);
    @(posedge SCLKg5);
    #2;
    closeTest("reset state");

    for (int f = 0; f < 20; f++) begin
      fillWords();
      rng = xorshift(rng);
      runFrame(int'(rng % 32'd16), 0, 1'b0, 1'b0, 1'b0);
    end
    closeTest("single-word frames");

    fillWords();
    rng = xorshift(rng);
    runFrame(3 + int'(rng % 32'd13), 3, 1'b0, 1'b0, 1'b0);
    fillWords();
    runFrame(7, 17, 1'b0, 1'b0, 1'b0);  // Slot number wraps past 15
    closeTest("multiword frames");

    fillWords();
    rng = xorshift(rng);
    runFrame(3 + int'(rng % 32'd13), 2, 1'b1, 1'b0, 1'b0);
    fillWords();
    runFrame(9, 0, 1'b1, 1'b0, 1'b0);
    closeTest("autobuffer");

    fillWords();
    rng = xorshift(rng);
    runFrame(4 + int'(rng % 32'd12), 0, 1'b0, 1'b1, 1'b0);
    closeTest("external frame sync");

    fillWords();
    runFrame(15, 1, 1'b0, 1'b1, 1'b1);
    closeTest("ignored sync");

    $display("Tests run %0d, failing %0d, errors %0d", testsRun, testsFailing, errCnt);
    if (testsFailing == 0 && errCnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/sportPkg.sv
rtl/txWordIf.sv
rtl/frameSyncGen.sv
rtl/txWordBuffer.sv
rtl/txShiftCtl.sv
rtl/txSerialOut.sv
rtl/sportTx.sv
tests/sportTxTb.sv

// ==== Makefile ====
# Verilator build and run for the SPORT transmit testbench

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= sportTxTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR FILELIST TOP BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "test passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
